//--- sim.f
src/soc_pkg.sv
src/wb_if.sv
src/wb_arbiter.sv
src/wb_decoder.sv
src/sram_store.sv
src/gpio_control.sv
src/la_control.sv
src/user_soc_top.sv
tests/tb_user_soc.sv

//--- run_sim.sh
#!/bin/sh
# Build the user-area shell testbench with Verilator and run it
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module tb_user_soc -f sim.f &&
./obj_dir/Vtb_user_soc | tee /dev/stderr | grep -q "TEST OK" &&
echo "Simulation passed" ||
{ echo "Simulation failed"; exit 1; }

//--- tests/tb_user_soc.sv
////////////////////////////////////////////////////////////
// Testbench for the user-area shell
// Table-driven bus cycles, pad muxing and arbitration
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module tb_user_soc;
    localparam int          ACK_LIMIT  = 20;          // Negedges before giving up
    localparam int          SINGLE_LAT = 2;           // Grant edge, then target ack edge
    localparam int          LOSER_LAT  = 6;           // Winner's 2, its drop, idle, own 2
    localparam int unsigned SEED       = 44889;
    localparam bit          HOST       = 1'b0;
    localparam bit          TEAM       = 1'b1;
    localparam logic [31:0] ALL        = 32'hFFFF_FFFF;
    localparam logic [31:0] HI_MASK    = 32'h0000_003F;   // Pad bits 37:32
    localparam logic [31:0] OUT_LO     = 32'hA5A5_0F0F;
    localparam logic [5:0]  OUT_HI     = 6'h2B;
    localparam logic [31:0] OEB_LO     = 32'h0000_FFFF;
    localparam logic [5:0]  OEB_HI     = 6'h15;
    localparam logic [31:0] OWN_LO     = 32'hFF00_00F0;
    localparam logic [5:0]  OWN_HI     = 6'h0C;
    localparam logic [31:0] LA_VAL     = 32'h1234_5678;
    localparam logic [31:0] LA_OWN_VAL = 32'h0F0F_00FF;
    localparam logic [31:0] PAIR_A     = 32'hCAFE_0001;
    localparam logic [31:0] PAIR_B     = 32'hCAFE_0002;

    typedef struct {
        string       name;
        bit          team;      // Issuing manager
        bit          we;
        logic [31:0] adr;
        logic [3:0]  sel;
        logic [31:0] dat;
        logic [31:0] exp;
        logic [31:0] mask;      // Read bits compared, 0 for writes
    } entry_t;

    logic        wb_clk_i;
    logic        reset_i;
    logic        host_cyc_i;
    logic        host_stb_i;
    logic        host_we_i;
    logic [3:0]  host_sel_i;
    logic [31:0] host_adr_i;
    logic [31:0] host_dat_i;
    logic        host_ack_o;
    logic [31:0] host_dat_o;
    logic        team_cyc_i;
    logic        team_stb_i;
    logic        team_we_i;
    logic [3:0]  team_sel_i;
    logic [31:0] team_adr_i;
    logic [31:0] team_dat_i;
    logic        team_ack_o;
    logic [31:0] team_dat_o;
    logic [37:0] team_gpio_out_i;
    logic [37:0] team_gpio_oeb_i;
    logic [37:0] io_in_i;
    logic [31:0] team_la_i;
    logic [37:0] io_out_o;
    logic [37:0] io_oeb_o;
    logic [31:0] la_data_o;

    entry_t tbl[$];
    int     tests = 0;
    int     errors = 0;
    bit     last_team = 1'b1;   // Reset leaves host ahead in a tie

    user_soc_top i_dut (.*);

    initial begin
        wb_clk_i = 1'b0;
        forever #2 wb_clk_i = ~wb_clk_i;
    end

    function automatic void report_mismatch(string name, logic [63:0] exp, logic [63:0] act);
        errors++;
        $display("[ERROR] %s expected %h actual %h", name, exp, act);
    endfunction

    task automatic finish_test(string name, int err0);
        tests++;
        $display("%-18s %s", name, (errors == err0) ? "passed" : "failed");
    endtask

    // Old word with the selected byte lanes replaced
    function automatic logic [31:0] merge_lanes(logic [31:0] old, logic [31:0] nw,
                                                logic [3:0] sel);
        logic [31:0] m;
        m = old;
        for (int b = 0; b < 4; b++) begin
            if (sel[b]) m[b*8 +: 8] = nw[b*8 +: 8];
        end
        return m;
    endfunction

    // Per bit, owner 1 takes the team value
    function automatic logic [63:0] owner_pick(logic [63:0] own, logic [63:0] team,
                                               logic [63:0] regv);
        logic [63:0] p;
        for (int i = 0; i < 64; i++) p[i] = own[i] ? team[i] : regv[i];
        return p;
    endfunction

    function automatic void add_write(string name, bit team, logic [31:0] adr,
                                      logic [3:0] sel, logic [31:0] dat);
        tbl.push_back('{name, team, 1'b1, adr, sel, dat, 32'h0, 32'h0});
    endfunction

    function automatic void add_read(string name, bit team, logic [31:0] adr,
                                     logic [31:0] exp, logic [31:0] mask);
        tbl.push_back('{name, team, 1'b0, adr, 4'hF, 32'h0, exp, mask});
    endfunction

    // Count negedges up to the manager's ack
    task automatic wait_ack(input bit team, output int lat);
        int n;
        n = 0;
        do begin
            @(negedge wb_clk_i);
            n++;
        end while (!(team ? team_ack_o : host_ack_o) && n < ACK_LIMIT);
        if (!(team ? team_ack_o : host_ack_o)) begin
            $display("Timeout: the %s manager never saw an ack", team ? "team" : "host");
            $display("TEST FAILED");
            $finish;
        end else begin
            lat = n - 1;                     // First negedge follows the drive edge
        end
    endtask

    task automatic host_cycle(input bit we, input logic [31:0] adr, input logic [3:0] sel,
                              input logic [31:0] dat, output logic [31:0] rd, output int lat);
        @(posedge wb_clk_i);
        host_cyc_i <= 1'b1;
        host_stb_i <= 1'b1;
        host_we_i  <= we;
        host_sel_i <= sel;
        host_adr_i <= adr;
        host_dat_i <= dat;
        wait_ack(HOST, lat);
        rd = host_dat_o;                     // Valid with ack
        @(posedge wb_clk_i);
        host_cyc_i <= 1'b0;                  // Cycle after ack
        host_stb_i <= 1'b0;
    endtask

    task automatic team_cycle(input bit we, input logic [31:0] adr, input logic [3:0] sel,
                              input logic [31:0] dat, output logic [31:0] rd, output int lat);
        @(posedge wb_clk_i);
        team_cyc_i <= 1'b1;
        team_stb_i <= 1'b1;
        team_we_i  <= we;
        team_sel_i <= sel;
        team_adr_i <= adr;
        team_dat_i <= dat;
        wait_ack(TEAM, lat);
        rd = team_dat_o;
        @(posedge wb_clk_i);
        team_cyc_i <= 1'b0;
        team_stb_i <= 1'b0;
    endtask

    task automatic run_entries(int first, int last);
        entry_t      e;
        logic [31:0] rd;
        int          lat;
        int          err0;
        for (int i = first; i < last; i++) begin
            e = tbl[i];
            err0 = errors;
            if (e.team) team_cycle(e.we, e.adr, e.sel, e.dat, rd, lat);
            else        host_cycle(e.we, e.adr, e.sel, e.dat, rd, lat);
            last_team = e.team;
            if (lat != SINGLE_LAT) report_mismatch({e.name, " latency"},
                                                   64'(SINGLE_LAT), 64'(lat));
            if ((rd & e.mask) !== (e.exp & e.mask)) report_mismatch(e.name,
                                                   64'(e.exp & e.mask), 64'(rd & e.mask));
            finish_test(e.name, err0);
        end
    endtask

    // Winner is the manager not granted last, loser waits out the handoff
    task automatic check_order(string name, int lat_h, int lat_t);
        bit win_team;
        win_team = !last_team;
        if ((win_team ? lat_t : lat_h) != SINGLE_LAT)
            report_mismatch({name, " winner latency"}, 64'(SINGLE_LAT),
                            64'(win_team ? lat_t : lat_h));
        if ((win_team ? lat_h : lat_t) != LOSER_LAT)
            report_mismatch({name, " loser latency"}, 64'(LOSER_LAT),
                            64'(win_team ? lat_h : lat_t));
        last_team = !win_team;               // Loser was granted last
    endtask

    task automatic check_pads(string name, bit owned);
        logic [37:0] own_g;
        logic [31:0] own_l;
        logic [63:0] exp_out;
        logic [63:0] exp_oeb;
        logic [63:0] exp_la;
        int          err0;
        err0    = errors;
        own_g   = owned ? {OWN_HI, OWN_LO} : 38'h0;
        own_l   = owned ? LA_OWN_VAL : 32'h0;
        @(negedge wb_clk_i);
        exp_out = owner_pick({26'h0, own_g}, {26'h0, team_gpio_out_i}, {26'h0, OUT_HI, OUT_LO});
        exp_oeb = owner_pick({26'h0, own_g}, {26'h0, team_gpio_oeb_i}, {26'h0, OEB_HI, OEB_LO});
        exp_la  = owner_pick({32'h0, own_l}, {32'h0, team_la_i}, {32'h0, LA_VAL});
        if ({26'h0, io_out_o} !== exp_out) report_mismatch({name, " io_out"}, exp_out,
                                                           {26'h0, io_out_o});
        if ({26'h0, io_oeb_o} !== exp_oeb) report_mismatch({name, " io_oeb"}, exp_oeb,
                                                           {26'h0, io_oeb_o});
        if ({32'h0, la_data_o} !== exp_la) report_mismatch({name, " la_data"}, exp_la,
                                                           {32'h0, la_data_o});
        finish_test(name, err0);
    endtask

    initial begin
        logic [63:0] rnd_in;
        logic [63:0] rnd;
        logic [31:0] sram_40;
        logic [31:0] rd_h;
        logic [31:0] rd_t;
        int          lat_h;
        int          lat_t;
        int          err0;
        int          part_a;
        void'($urandom(SEED));
        rnd_in = {$urandom, $urandom};
        reset_i    <= 1'b1;
        host_cyc_i <= 1'b0;
        host_stb_i <= 1'b0;
        host_we_i  <= 1'b0;
        host_sel_i <= 4'h0;
        host_adr_i <= 32'h0;
        host_dat_i <= 32'h0;
        team_cyc_i <= 1'b0;
        team_stb_i <= 1'b0;
        team_we_i  <= 1'b0;
        team_sel_i <= 4'h0;
        team_adr_i <= 32'h0;
        team_dat_i <= 32'h0;
        io_in_i    <= rnd_in[37:0];
        rnd = {$urandom, $urandom};
        team_gpio_out_i <= rnd[37:0];
        rnd = {$urandom, $urandom};
        team_gpio_oeb_i <= rnd[37:0];
        team_la_i       <= $urandom;

        // SRAM, register and unmapped traffic, ownership still off
        sram_40 = merge_lanes(32'h1122_3344, 32'h99AA_BBCC, 4'hA);
        add_write("sram_host_word", HOST, 32'h3000_0040, 4'hF, 32'h1122_3344);
        add_write("sram_team_word", TEAM, 32'h3000_0044, 4'hF, 32'hA0B0_C0D0);
        add_write("sram_host_lanes", HOST, 32'h3000_0044, 4'h5, 32'h5566_7788);
        add_write("sram_team_lanes", TEAM, 32'h3000_0040, 4'hA, 32'h99AA_BBCC);
        add_read("sram_team_merge", TEAM, 32'h3000_0044,
                 merge_lanes(32'hA0B0_C0D0, 32'h5566_7788, 4'h5), ALL);
        add_read("sram_host_merge", HOST, 32'h3000_0040, sram_40, ALL);
        add_write("gpio_out_lo", HOST, 32'h3100_0000, 4'hF, OUT_LO);
        add_write("gpio_out_hi", TEAM, 32'h3100_0010, 4'hF, {26'h0, OUT_HI});
        add_write("gpio_oeb_lo", HOST, 32'h3100_0004, 4'hF, OEB_LO);
        add_write("gpio_oeb_hi", TEAM, 32'h3100_0014, 4'hF, {26'h0, OEB_HI});
        add_read("gpio_out_rd", TEAM, 32'h3100_0000, OUT_LO, ALL);
        add_read("gpio_oeb_hi_rd", HOST, 32'h3100_0014, {26'h0, OEB_HI}, HI_MASK);
        add_read("gpio_in_lo", HOST, 32'h3100_000C, rnd_in[31:0], ALL);
        add_read("gpio_in_hi", TEAM, 32'h3100_001C, {26'h0, rnd_in[37:32]}, HI_MASK);
        add_write("la_data", HOST, 32'h3200_0000, 4'hF, LA_VAL);
        add_read("la_data_rd", TEAM, 32'h3200_0000, LA_VAL, ALL);
        add_read("nomap_rd", HOST, 32'h4000_0040, soc_pkg::UNMAPPED_DATA, ALL);
        add_write("nomap_wr", TEAM, 32'h4000_0040, 4'hF, 32'hDEAD_BEEF);   // Aliases SRAM word
        add_read("nomap_no_effect", HOST, 32'h3000_0040, sram_40, ALL);
        part_a = tbl.size();
        add_write("gpio_own_lo", TEAM, 32'h3100_0008, 4'hF, OWN_LO);
        add_write("gpio_own_hi", HOST, 32'h3100_0018, 4'hF, {26'h0, OWN_HI});
        add_read("gpio_own_hi_rd", TEAM, 32'h3100_0018, {26'h0, OWN_HI}, HI_MASK);
        add_write("la_own", TEAM, 32'h3200_0004, 4'hF, LA_OWN_VAL);
        add_read("la_own_rd", HOST, 32'h3200_0004, LA_OWN_VAL, ALL);   // Host granted last

        repeat (4) @(posedge wb_clk_i);
        reset_i <= 1'b0;
        @(negedge wb_clk_i);
        err0 = errors;
        if (host_ack_o !== 1'b0) report_mismatch("reset host_ack", 64'h0, 64'(host_ack_o));
        if (team_ack_o !== 1'b0) report_mismatch("reset team_ack", 64'h0, 64'(team_ack_o));
        if (io_oeb_o !== {38{1'b1}}) report_mismatch("reset io_oeb", 64'({38{1'b1}}),
                                                     64'(io_oeb_o));
        if (la_data_o !== 32'h0) report_mismatch("reset la_data", 64'h0, 64'(la_data_o));
        finish_test("reset_state", err0);

        // Same-edge requests from idle
        err0 = errors;
        fork
            host_cycle(1'b1, 32'h3000_0080, 4'hF, PAIR_A, rd_h, lat_h);
            team_cycle(1'b1, 32'h3000_0084, 4'hF, PAIR_B, rd_t, lat_t);
        join
        check_order("arb_pair_1", lat_h, lat_t);
        finish_test("arb_pair_1", err0);

        run_entries(0, part_a);
        check_pads("pads_register", 1'b0);
        run_entries(part_a, tbl.size());
        check_pads("pads_owned", 1'b1);

        err0 = errors;
        fork
            host_cycle(1'b0, 32'h3000_0084, 4'hF, 32'h0, rd_h, lat_h);
            team_cycle(1'b0, 32'h3000_0080, 4'hF, 32'h0, rd_t, lat_t);
        join
        check_order("arb_pair_2", lat_h, lat_t);
        if (rd_h !== PAIR_B) report_mismatch("arb_pair_2 host data", 64'(PAIR_B), 64'(rd_h));
        if (rd_t !== PAIR_A) report_mismatch("arb_pair_2 team data", 64'(PAIR_A), 64'(rd_t));
        finish_test("arb_pair_2", err0);

        $display("Ran %0d tests with %0d errors", tests, errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

//--- src/user_soc_top.sv
////////////////////////////////////////////////////////////
// User-area shell with two managers on one peripheral bus
// Arbiter, decoder, SRAM, GPIO and LA control
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module user_soc_top (
    input  logic                       wb_clk_i,
    input  logic                       reset_i,

    // Host manager
    input  logic                       host_cyc_i,
    input  logic                       host_stb_i,
    input  logic                       host_we_i,
    input  logic [soc_pkg::WB_SW-1:0]  host_sel_i,
    input  logic [soc_pkg::WB_AW-1:0]  host_adr_i,
    input  logic [soc_pkg::WB_DW-1:0]  host_dat_i,
    output logic                       host_ack_o,
    output logic [soc_pkg::WB_DW-1:0]  host_dat_o,

    // Team manager
    input  logic                       team_cyc_i,
    input  logic                       team_stb_i,
    input  logic                       team_we_i,
    input  logic [soc_pkg::WB_SW-1:0]  team_sel_i,
    input  logic [soc_pkg::WB_AW-1:0]  team_adr_i,
    input  logic [soc_pkg::WB_DW-1:0]  team_dat_i,
    output logic                       team_ack_o,
    output logic [soc_pkg::WB_DW-1:0]  team_dat_o,

    // Team pad and analyzer values
    input  logic [soc_pkg::GPIO_W-1:0] team_gpio_out_i,
    input  logic [soc_pkg::GPIO_W-1:0] team_gpio_oeb_i,
    input  logic [soc_pkg::GPIO_W-1:0] io_in_i,
    input  logic [soc_pkg::LA_W-1:0]   team_la_i,
    output logic [soc_pkg::GPIO_W-1:0] io_out_o,
    output logic [soc_pkg::GPIO_W-1:0] io_oeb_o,   // Active low
    output logic [soc_pkg::LA_W-1:0]   la_data_o
);
    wb_if host_bus ();
    wb_if team_bus ();
    wb_if shared_bus ();   // Arbiter to decoder
    wb_if sram_bus ();
    wb_if gpio_bus ();
    wb_if la_bus ();

    // Host ports into the bundle
    assign host_bus.cyc   = host_cyc_i;
    assign host_bus.stb   = host_stb_i;
    assign host_bus.we    = host_we_i;
    assign host_bus.sel   = host_sel_i;
    assign host_bus.adr   = host_adr_i;
    assign host_bus.dat_w = host_dat_i;
    assign host_ack_o     = host_bus.ack;
    assign host_dat_o     = host_bus.dat_r;

    // Team ports
    assign team_bus.cyc   = team_cyc_i;
    assign team_bus.stb   = team_stb_i;
    assign team_bus.we    = team_we_i;
    assign team_bus.sel   = team_sel_i;
    assign team_bus.adr   = team_adr_i;
    assign team_bus.dat_w = team_dat_i;
    assign team_ack_o     = team_bus.ack;
    assign team_dat_o     = team_bus.dat_r;

    wb_arbiter i_arbiter (
        .wb_clk_i (wb_clk_i),
        .reset_i  (reset_i),
        .host_s   (host_bus),
        .team_s   (team_bus),
        .bus_m    (shared_bus)
    );

    wb_decoder i_decoder (
        .wb_clk_i (wb_clk_i),
        .reset_i  (reset_i),
        .bus_s    (shared_bus),
        .sram_m   (sram_bus),
        .gpio_m   (gpio_bus),
        .la_m     (la_bus)
    );

    sram_store i_sram (
        .wb_clk_i (wb_clk_i),
        .reset_i  (reset_i),
        .bus_s    (sram_bus)
    );

    gpio_control i_gpio (
        .wb_clk_i        (wb_clk_i),
        .reset_i         (reset_i),
        .bus_s           (gpio_bus),
        .team_gpio_out_i (team_gpio_out_i),
        .team_gpio_oeb_i (team_gpio_oeb_i),
        .io_in_i         (io_in_i),
        .io_out_o        (io_out_o),
        .io_oeb_o        (io_oeb_o)
    );

    la_control i_la (
        .wb_clk_i  (wb_clk_i),
        .reset_i   (reset_i),
        .bus_s     (la_bus),
        .team_la_i (team_la_i),
        .la_data_o (la_data_o)
    );

endmodule

//--- src/la_control.sv
////////////////////////////////////////////////////////////
// Logic analyzer data and ownership registers
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module la_control (
    input  logic                     wb_clk_i,
    input  logic                     reset_i,
    wb_if.peripheral                 bus_s,
    input  logic [soc_pkg::LA_W-1:0] team_la_i,
    output logic [soc_pkg::LA_W-1:0] la_data_o
);
    logic [soc_pkg::LA_W-1:0]  data_q;
    logic [soc_pkg::LA_W-1:0]  own_q;    // 1 passes the team bit
    logic [soc_pkg::WB_DW-1:0] dat_q;
    logic                      ack_q;
    logic                      access;

    assign access = bus_s.cyc && bus_s.stb && !ack_q;

    always_ff @(posedge wb_clk_i) begin
        if (reset_i) begin
            ack_q  <= 1'b0;
            data_q <= '0;
            own_q  <= '0;
        end else begin
            ack_q <= access;
            if (access && bus_s.we) begin
                if (bus_s.adr[3:0] == soc_pkg::LA_DATA) data_q <= bus_s.dat_w;
                if (bus_s.adr[3:0] == soc_pkg::LA_OWN)  own_q  <= bus_s.dat_w;
            end
        end
    end

    // Readback of both registers
    always_ff @(posedge wb_clk_i) begin
        if (access) begin
            case (bus_s.adr[3:0])
                soc_pkg::LA_DATA: dat_q <= data_q;
                soc_pkg::LA_OWN:  dat_q <= own_q;
                default:          dat_q <= soc_pkg::UNMAPPED_DATA;
            endcase
        end
    end

    assign bus_s.ack   = ack_q;
    assign bus_s.dat_r = dat_q;
    assign la_data_o   = (own_q & team_la_i) | (~own_q & data_q);   // Bitwise owner mux

endmodule

//--- src/gpio_control.sv
////////////////////////////////////////////////////////////
// Pad output, enable and ownership registers
// Per pin the register or the team drives the pad
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module gpio_control (
    input  logic                       wb_clk_i,
    input  logic                       reset_i,
    wb_if.peripheral                   bus_s,
    input  logic [soc_pkg::GPIO_W-1:0] team_gpio_out_i,
    input  logic [soc_pkg::GPIO_W-1:0] team_gpio_oeb_i,
    input  logic [soc_pkg::GPIO_W-1:0] io_in_i,
    output logic [soc_pkg::GPIO_W-1:0] io_out_o,
    output logic [soc_pkg::GPIO_W-1:0] io_oeb_o
);
    logic [soc_pkg::GPIO_W-1:0] out_q;
    logic [soc_pkg::GPIO_W-1:0] oeb_q;   // Active low enable
    logic [soc_pkg::GPIO_W-1:0] own_q;   // 1 hands the pin to the team
    logic [soc_pkg::WB_DW-1:0]  dat_q;
    logic                       ack_q;
    logic                       access;
    logic                       hi;      // Upper pad word

    // Write one half of a pad register
    function automatic logic [soc_pkg::GPIO_W-1:0] wr_half(
        input logic [soc_pkg::GPIO_W-1:0] old,
        input logic [31:0]                d,
        input logic                       upper
    );
        return upper ? {d[soc_pkg::GPIO_W-33:0], old[31:0]}
                     : {old[soc_pkg::GPIO_W-1:32], d};
    endfunction

    // Read one half, upper bits zero-filled
    function automatic logic [31:0] rd_half(
        input logic [soc_pkg::GPIO_W-1:0] r,
        input logic                       upper
    );
        return upper ? {{(64-soc_pkg::GPIO_W){1'b0}}, r[soc_pkg::GPIO_W-1:32]} : r[31:0];
    endfunction

    assign access = bus_s.cyc && bus_s.stb && !ack_q;
    assign hi     = bus_s.adr[soc_pkg::GPIO_HI_BIT];

    always_ff @(posedge wb_clk_i) begin
        if (reset_i) begin
            ack_q <= 1'b0;
            out_q <= '0;
            oeb_q <= '1;                 // Pads start as inputs
            own_q <= '0;
        end else begin
            ack_q <= access;
            if (access && bus_s.we) begin
                case (bus_s.adr[3:0])
                    soc_pkg::GPIO_OUT: out_q <= wr_half(out_q, bus_s.dat_w, hi);
                    soc_pkg::GPIO_OEB: oeb_q <= wr_half(oeb_q, bus_s.dat_w, hi);
                    soc_pkg::GPIO_OWN: own_q <= wr_half(own_q, bus_s.dat_w, hi);
                    default: ;           // GPIO_IN is read only
                endcase
            end
        end
    end

    always_ff @(posedge wb_clk_i) begin
        if (access) begin
            case (bus_s.adr[3:0])
                soc_pkg::GPIO_OUT: dat_q <= rd_half(out_q, hi);
                soc_pkg::GPIO_OEB: dat_q <= rd_half(oeb_q, hi);
                soc_pkg::GPIO_OWN: dat_q <= rd_half(own_q, hi);
                soc_pkg::GPIO_IN:  dat_q <= rd_half(io_in_i, hi);
                default:           dat_q <= soc_pkg::UNMAPPED_DATA;
            endcase
        end
    end

    assign bus_s.ack   = ack_q;
    assign bus_s.dat_r = dat_q;

    // Per-pin owner select
    assign io_out_o = (own_q & team_gpio_out_i) | (~own_q & out_q);
    assign io_oeb_o = (own_q & team_gpio_oeb_i) | (~own_q & oeb_q);

endmodule

//--- src/sram_store.sv
////////////////////////////////////////////////////////////
// 256x32 word store on the shared Wishbone bus
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module sram_store (
    input  logic     wb_clk_i,
    input  logic     reset_i,
    wb_if.peripheral bus_s
);
    logic [soc_pkg::WB_DW-1:0] mem [soc_pkg::SRAM_DEPTH];
    logic [soc_pkg::WB_DW-1:0] dat_q;
    logic [7:0]                idx;           // Word index
    logic                      ack_q;
    logic                      access;

    assign idx    = bus_s.adr[9:2];
    assign access = bus_s.cyc && bus_s.stb && !ack_q;   // New cycle only

    always_ff @(posedge wb_clk_i) begin
        if (reset_i) ack_q <= 1'b0;
        else         ack_q <= access;
    end

    // Byte-lane writes, commit on the ack edge
    always_ff @(posedge wb_clk_i) begin
        if (access && bus_s.we) begin
            for (int b = 0; b < soc_pkg::WB_SW; b++) begin
                if (bus_s.sel[b]) mem[idx][b*8 +: 8] <= bus_s.dat_w[b*8 +: 8];
            end
        end
    end

    always_ff @(posedge wb_clk_i) begin
        if (access) dat_q <= mem[idx];   // Stored word, valid with ack
    end

    assign bus_s.ack   = ack_q;
    assign bus_s.dat_r = dat_q;

    // Manager keeps cyc up until it sees ack
    a_ack_in_cyc: assert property (@(posedge wb_clk_i) disable iff (reset_i)
        bus_s.ack |-> bus_s.cyc);

endmodule

//--- src/wb_decoder.sv
////////////////////////////////////////////////////////////
// Shared bus address decoder for SRAM, GPIO and LA
// Unmapped cycles get a local zero-data ack
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module wb_decoder (
    input  logic     wb_clk_i,
    input  logic     reset_i,
    wb_if.peripheral bus_s,
    wb_if.manager    sram_m,
    wb_if.manager    gpio_m,
    wb_if.manager    la_m
);
    soc_pkg::wb_target_t tgt;
    logic                nomap_ack_q;

    // Target from the top address byte
    always_comb begin
        case (bus_s.adr[31:24])
            soc_pkg::SRAM_BASE[31:24]: tgt = soc_pkg::TGT_SRAM;
            soc_pkg::GPIO_BASE[31:24]: tgt = soc_pkg::TGT_GPIO;
            soc_pkg::LA_BASE[31:24]:   tgt = soc_pkg::TGT_LA;
            default:                   tgt = soc_pkg::TGT_NONE;
        endcase
    end

    // Only the selected target sees cyc
    assign sram_m.cyc = bus_s.cyc && (tgt == soc_pkg::TGT_SRAM);
    assign gpio_m.cyc = bus_s.cyc && (tgt == soc_pkg::TGT_GPIO);
    assign la_m.cyc   = bus_s.cyc && (tgt == soc_pkg::TGT_LA);

    // Rest of the request is broadcast
    assign sram_m.adr   = bus_s.adr;
    assign sram_m.dat_w = bus_s.dat_w;
    assign gpio_m.adr   = bus_s.adr;
    assign gpio_m.dat_w = bus_s.dat_w;
    assign la_m.adr     = bus_s.adr;
    assign la_m.dat_w   = bus_s.dat_w;
    assign sram_m.sel   = bus_s.sel;
    assign sram_m.we    = bus_s.we;
    assign gpio_m.sel   = bus_s.sel;
    assign gpio_m.we    = bus_s.we;
    assign la_m.sel     = bus_s.sel;
    assign la_m.we      = bus_s.we;
    assign sram_m.stb   = bus_s.stb;
    assign gpio_m.stb   = bus_s.stb;
    assign la_m.stb     = bus_s.stb;

    // Local responder for holes in the map
    always_ff @(posedge wb_clk_i) begin
        if (reset_i) begin
            nomap_ack_q <= 1'b0;
        end else begin
            nomap_ack_q <= bus_s.cyc && bus_s.stb && !nomap_ack_q
                           && (tgt == soc_pkg::TGT_NONE);
        end
    end

    // Response back from the selected target
    always_comb begin
        case (tgt)
            soc_pkg::TGT_SRAM: begin
                bus_s.ack   = sram_m.ack;
                bus_s.dat_r = sram_m.dat_r;
            end
            soc_pkg::TGT_GPIO: begin
                bus_s.ack   = gpio_m.ack;
                bus_s.dat_r = gpio_m.dat_r;
            end
            soc_pkg::TGT_LA: begin
                bus_s.ack   = la_m.ack;
                bus_s.dat_r = la_m.dat_r;
            end
            default: begin
                bus_s.ack   = nomap_ack_q;
                bus_s.dat_r = soc_pkg::UNMAPPED_DATA;
            end
        endcase
    end

    // One target selected, and one responder acking
    a_one_target: assert property (@(posedge wb_clk_i) disable iff (reset_i)
        $onehot0({sram_m.cyc, gpio_m.cyc, la_m.cyc})
        && $onehot0({sram_m.ack, gpio_m.ack, la_m.ack, nomap_ack_q}));

endmodule

//--- src/wb_arbiter.sv
////////////////////////////////////////////////////////////
// Round-robin arbiter for host and team Wishbone managers
// Grant is held until the owner drops cyc
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module wb_arbiter (
    input  logic     wb_clk_i,
    input  logic     reset_i,
    wb_if.peripheral host_s,
    wb_if.peripheral team_s,
    wb_if.manager    bus_m
);
    soc_pkg::arb_state_t state_q;
    logic                last_team_q;   // Team got the last grant
    logic                host_req;
    logic                team_req;
    logic                host_gnt;
    logic                team_gnt;

    assign host_req = host_s.cyc && host_s.stb;
    assign team_req = team_s.cyc && team_s.stb;
    assign host_gnt = (state_q == soc_pkg::ARB_HOST);
    assign team_gnt = (state_q == soc_pkg::ARB_TEAM);

    always_ff @(posedge wb_clk_i) begin
        if (reset_i) begin
            state_q     <= soc_pkg::ARB_IDLE;
            last_team_q <= 1'b1;        // So host wins the first tie
        end else begin
            case (state_q)
                soc_pkg::ARB_IDLE: begin
                    if (host_req && (!team_req || last_team_q)) begin
                        state_q     <= soc_pkg::ARB_HOST;
                        last_team_q <= 1'b0;
                    end else if (team_req) begin
                        state_q     <= soc_pkg::ARB_TEAM;
                        last_team_q <= 1'b1;
                    end
                end
                soc_pkg::ARB_HOST: if (!host_s.cyc) state_q <= soc_pkg::ARB_IDLE;
                soc_pkg::ARB_TEAM: if (!team_s.cyc) state_q <= soc_pkg::ARB_IDLE;
                default:           state_q <= soc_pkg::ARB_IDLE;
            endcase
        end
    end

    // Owner's request onto the shared bus
    assign bus_m.adr   = team_gnt ? team_s.adr   : host_s.adr;
    assign bus_m.dat_w = team_gnt ? team_s.dat_w : host_s.dat_w;
    assign bus_m.sel   = team_gnt ? team_s.sel   : host_s.sel;
    assign bus_m.we    = team_gnt ? team_s.we    : host_s.we;
    assign bus_m.cyc   = (host_gnt && host_s.cyc) || (team_gnt && team_s.cyc); // Idle keeps bus quiet
    assign bus_m.stb   = (host_gnt && host_s.stb) || (team_gnt && team_s.stb);

    // Waiting manager sees no ack
    assign host_s.ack   = host_gnt && bus_m.ack;
    assign team_s.ack   = team_gnt && bus_m.ack;
    assign host_s.dat_r = host_gnt ? bus_m.dat_r : '0;
    assign team_s.dat_r = team_gnt ? bus_m.dat_r : '0;

    // Target ack lands on the same grant that issued the request
    a_ack_on_grant: assert property (@(posedge wb_clk_i) disable iff (reset_i)
        bus_m.ack |-> (state_q != soc_pkg::ARB_IDLE) && (state_q == $past(state_q)));

    // No switch mid-cycle
    a_grant_stable: assert property (@(posedge wb_clk_i) disable iff (reset_i)
        bus_m.cyc && !bus_m.ack |=> bus_m.cyc && $stable(bus_m.adr) && $stable(bus_m.we));

endmodule

//--- src/wb_if.sv
////////////////////////////////////////////////////////////
// Wishbone classic bus bundle
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

interface wb_if;
    logic [soc_pkg::WB_AW-1:0] adr;
    logic [soc_pkg::WB_DW-1:0] dat_w;   // Manager to peripheral
    logic [soc_pkg::WB_DW-1:0] dat_r;   // Peripheral to manager
    logic [soc_pkg::WB_SW-1:0] sel;
    logic                      we;
    logic                      stb;
    logic                      cyc;
    logic                      ack;     // One-cycle pulse

    // Request side
    modport manager (output adr, dat_w, sel, we, stb, cyc,
                     input  dat_r, ack);

    // Answering side
    modport peripheral (input  adr, dat_w, sel, we, stb, cyc,
                        output dat_r, ack);
endinterface

//--- src/soc_pkg.sv
////////////////////////////////////////////////////////////
// Shared definitions for the user-area shell
// Bus widths, address map, register offsets and enums
////////////////////////////////////////////////////////////
package soc_pkg;

    // Wishbone bus widths
    localparam int WB_AW = 32;
    localparam int WB_DW = 32;
    localparam int WB_SW = 4;              // One sel bit per byte lane

    localparam int GPIO_W     = 38;        // Breakout pads
    localparam int LA_W       = 32;
    localparam int SRAM_DEPTH = 256;       // Words

    // Target bases, decoded on bits 31:24
    localparam logic [31:0] SRAM_BASE = 32'h3000_0000;
    localparam logic [31:0] GPIO_BASE = 32'h3100_0000;
    localparam logic [31:0] LA_BASE   = 32'h3200_0000;

    // GPIO register offsets
    localparam logic [3:0] GPIO_OUT = 4'h0;
    localparam logic [3:0] GPIO_OEB = 4'h4;
    localparam logic [3:0] GPIO_OWN = 4'h8;
    localparam logic [3:0] GPIO_IN  = 4'hC;
    localparam int GPIO_HI_BIT = 4;        // Address bit that picks pad bits 37:32

    // Analyzer register offsets
    localparam logic [3:0] LA_DATA = 4'h0;
    localparam logic [3:0] LA_OWN  = 4'h4;

    localparam logic [31:0] UNMAPPED_DATA = 32'h0;

    typedef enum logic [1:0] {ARB_IDLE, ARB_HOST, ARB_TEAM} arb_state_t;

    typedef enum logic [1:0] {TGT_SRAM, TGT_GPIO, TGT_LA, TGT_NONE} wb_target_t;

endpackage
